//--- include/hdown_settings.svh
// Bus and memory settings for the hdown subsystem
// Address width, memory depth in halfwords, memory wait states

`ifndef HDOWN_SETTINGS_SVH
`define HDOWN_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Bus geometry
// ---------------------------------------------------------------------------

// Byte address width on both AHB-Lite sides
`define HDOWN_ADDR_WIDTH 16

// ---------------------------------------------------------------------------
// On-chip memory
// ---------------------------------------------------------------------------

// Number of 16-bit locations, so 2 KiB of storage
`define HDOWN_MEM_DEPTH 1024

// Low-ready cycles before each beat completes
`define HDOWN_WAIT_STATES 1

`endif

//--- design/ahb_pkg.sv
// AHB-Lite protocol encodings
// HTRANS and HSIZE types, HRESP codes

package ahb_pkg;

   // ------------------------------------------------------------------------
   // Transfer type
   // ------------------------------------------------------------------------

   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_BUSY   = 2'b01,
      HTRANS_NONSEQ = 2'b10,
      HTRANS_SEQ    = 2'b11
   } htrans_t;

   // ------------------------------------------------------------------------
   // Transfer size, only up to a word on this bus
   // ------------------------------------------------------------------------

   typedef enum logic [2:0] {
      HSIZE_BYTE = 3'b000,
      HSIZE_HALF = 3'b001,
      HSIZE_WORD = 3'b010
   } hsize_t;

   // Slave response codes
   localparam logic HRESP_OKAY  = 1'b0;
   localparam logic HRESP_ERROR = 1'b1;

endpackage

//--- design/cmd_pkg.sv
// Command port types
// Command size, data record width and the size-to-HSIZE mapping

package cmd_pkg;

   import ahb_pkg::*;

   // Size field of a command
   typedef enum logic [1:0] {
      CMD_BYTE = 2'b00,
      CMD_HALF = 2'b01,
      CMD_WORD = 2'b10
   } cmd_size_t;

   // Write data and read response payload
   typedef logic [31:0] cmd_data_t;

   // Command size onto the bus size encoding
   function automatic hsize_t cmd_size_to_hsize(input cmd_size_t size);
      hsize_t hs;
      case (size)
         CMD_BYTE: hs = HSIZE_BYTE;
         CMD_HALF: hs = HSIZE_HALF;
         default:  hs = HSIZE_WORD;
      endcase
      return hs;
   endfunction

endpackage

//--- design/ahb_cmd_master.sv
// Command-driven AHB-Lite master
// Address-phase and data-phase slots, error cancel and reissue, response output

`timescale 1ns/1ps
`include "hdown_settings.svh"

module ahb_cmd_master (
   input  logic                         HCLK,
   input  logic                         HRESETn,
   // Command port
   input  logic                         cmd_valid,
   output logic                         cmd_ready,
   input  logic                         cmd_write,
   input  cmd_pkg::cmd_size_t           cmd_size,
   input  logic [`HDOWN_ADDR_WIDTH-1:0] cmd_addr,
   input  cmd_pkg::cmd_data_t           cmd_wdata,
   // Response port
   output logic                         rsp_valid,
   output cmd_pkg::cmd_data_t           rsp_rdata,
   output logic                         rsp_err,
   // AHB-Lite master side
   output logic [`HDOWN_ADDR_WIDTH-1:0] haddr,
   output ahb_pkg::htrans_t             htrans,
   output ahb_pkg::hsize_t              hsize,
   output logic                         hwrite,
   output logic [31:0]                  hwdata,
   input  logic [31:0]                  hrdata,
   input  logic                         hready,
   input  logic                         hresp
);
   import ahb_pkg::*;
   import cmd_pkg::*;

   // ------------------------------------------------------------------------
   // Slot state
   // ------------------------------------------------------------------------

   // Address-phase slot
   logic                         ap_valid;
   logic                         ap_write;
   hsize_t                       ap_size;
   logic [`HDOWN_ADDR_WIDTH-1:0] ap_addr;
   cmd_data_t                    ap_wdata;

   // Data-phase slot, write data must hold for the whole phase
   logic                         dp_valid;
   logic                         dp_write;
   cmd_data_t                    dp_wdata;

   logic                         take;
   logic                         err_cycle;
   logic                         ap_done;
   logic                         dp_done;

   // ------------------------------------------------------------------------
   // Handshake terms
   // ------------------------------------------------------------------------

   // Both ERROR cycles, the pending address phase is pulled back to IDLE
   assign err_cycle = dp_valid & hresp;

   // Address phase accepted by the slave on this edge
   assign ap_done   = ap_valid & hready & ~err_cycle;
   assign dp_done   = dp_valid & hready;

   // Slot free now or freed on this edge
   assign cmd_ready = ~ap_valid | ap_done;
   assign take      = cmd_valid & cmd_ready;

   // Bus outputs straight from the slots
   assign htrans = (ap_valid && !err_cycle) ? HTRANS_NONSEQ : HTRANS_IDLE;
   assign haddr  = ap_addr;
   assign hsize  = ap_size;
   assign hwrite = ap_write;
   assign hwdata = dp_wdata;

   // ------------------------------------------------------------------------
   // Control registers
   // ------------------------------------------------------------------------

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         ap_valid  <= 1'b0;
         dp_valid  <= 1'b0;
         rsp_valid <= 1'b0;
         rsp_err   <= 1'b0;
      end else begin
         // A cancelled command stays in the slot and goes out again
         if (take) begin
            ap_valid <= 1'b1;
         end else if (ap_done) begin
            ap_valid <= 1'b0;
         end
         if (hready) begin
            dp_valid <= ap_done;
         end
         rsp_valid <= dp_done;
         if (dp_done) begin
            rsp_err <= hresp;
         end
      end
   end

   // ------------------------------------------------------------------------
   // Payload registers
   // ------------------------------------------------------------------------

   always_ff @(posedge HCLK) begin
      if (take) begin
         ap_write <= cmd_write;
         ap_size  <= cmd_size_to_hsize(cmd_size);
         ap_addr  <= cmd_addr;
         ap_wdata <= cmd_wdata;
      end
      if (ap_done) begin
         dp_write <= ap_write;
         dp_wdata <= ap_wdata;
      end
      // Read data only matters for reads
      if (dp_done && !dp_write) begin
         rsp_rdata <= hrdata;
      end
   end

endmodule

//--- design/ahb_downsizer.sv
// 32-to-16-bit AHB-Lite downsizing bridge
// Word split into two halfword beats, read half merge, write lane select

`timescale 1ns/1ps
`include "hdown_settings.svh"

module ahb_downsizer (
   input  logic                         HCLK,
   input  logic                         HRESETn,
   // 32-bit slave side
   input  logic [`HDOWN_ADDR_WIDTH-1:0] s_haddr,
   input  logic                         s_hsel,
   input  ahb_pkg::htrans_t             s_htrans,
   input  ahb_pkg::hsize_t              s_hsize,
   input  logic                         s_hwrite,
   input  logic                         s_hready,
   input  logic [31:0]                  s_hwdata,
   output logic [31:0]                  s_hrdata,
   output logic                         s_hreadyout,
   output logic                         s_hresp,
   // 16-bit master side
   output logic [`HDOWN_ADDR_WIDTH-1:0] m_haddr,
   output ahb_pkg::htrans_t             m_htrans,
   output ahb_pkg::hsize_t              m_hsize,
   output logic                         m_hwrite,
   output logic [15:0]                  m_hwdata,
   input  logic [15:0]                  m_hrdata,
   input  logic                         m_hready,
   input  logic                         m_hresp
);
   import ahb_pkg::*;

   // ------------------------------------------------------------------------
   // State
   // ------------------------------------------------------------------------

   // Second beat of a word still to be issued
   logic                         second_q;
   // Lower read half waiting for its partner
   logic                         rdata_valid_q;
   // Write data lane of the beat in data phase
   logic                         wlane_q;

   // Word-aligned part of the address and write flag of the split word
   logic [`HDOWN_ADDR_WIDTH-1:2] addr_q;
   logic                         write_q;
   logic [15:0]                  rdata_q;

   logic                         word_req;

   // ------------------------------------------------------------------------
   // Request decode
   // ------------------------------------------------------------------------

   // Word transfer accepted on the slave side
   assign word_req = s_hsel & s_htrans[1] & s_hready & (s_hsize == HSIZE_WORD);

   // ------------------------------------------------------------------------
   // Master-side address phase
   // ------------------------------------------------------------------------

   // Aligned word, so A+2 is an OR of bit 1
   assign m_haddr  = second_q ? {addr_q, 2'b10} : s_haddr;
   assign m_hwrite = second_q ? write_q : s_hwrite;

   // Never bursts, every beat is NONSEQ
   assign m_htrans = (second_q || (s_hsel && s_htrans[1])) ? HTRANS_NONSEQ : HTRANS_IDLE;

   // Words go out as halfwords, smaller sizes pass unchanged
   always_comb begin
      if (second_q || s_hsize == HSIZE_WORD) begin
         m_hsize = HSIZE_HALF;
      end else begin
         m_hsize = s_hsize;
      end
   end

   // ------------------------------------------------------------------------
   // Data path
   // ------------------------------------------------------------------------

   // Lane follows bit 1 of the beat in data phase
   assign m_hwdata = wlane_q ? s_hwdata[31:16] : s_hwdata[15:0];

   // Merge halves of a word, else replicate the halfword
   assign s_hrdata = rdata_valid_q ? {m_hrdata, rdata_q} : {m_hrdata, m_hrdata};

   // First half of a word is hidden from the master, including its error
   assign s_hreadyout = m_hready & ~second_q;
   assign s_hresp     = m_hresp & ~second_q;

   // ------------------------------------------------------------------------
   // Control registers
   // ------------------------------------------------------------------------

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         second_q      <= 1'b0;
         rdata_valid_q <= 1'b0;
         wlane_q       <= 1'b0;
      end else begin
         // Set on the first beat, cleared when the second beat is taken
         if ((s_hready && word_req) || (m_hready && second_q)) begin
            second_q <= word_req;
         end
         if (m_hready) begin
            rdata_valid_q <= second_q;
         end
         if (m_hready && m_htrans[1] && m_hwrite) begin
            wlane_q <= m_haddr[1];
         end
      end
   end

   // ------------------------------------------------------------------------
   // Payload registers
   // ------------------------------------------------------------------------

   always_ff @(posedge HCLK) begin
      if (word_req) begin
         addr_q  <= s_haddr[`HDOWN_ADDR_WIDTH-1:2];
         write_q <= s_hwrite;
      end
      // Lower half lands while the second beat is in address phase
      if (m_hready && second_q) begin
         rdata_q <= m_hrdata;
      end
   end

endmodule

//--- design/ahb_sram16.sv
// 16-bit AHB-Lite SRAM slave
// Byte lanes, fixed wait states, two-cycle ERROR beyond the memory depth

`timescale 1ns/1ps
`include "hdown_settings.svh"

module ahb_sram16 (
   input  logic                         HCLK,
   input  logic                         HRESETn,
   input  logic                         hsel,
   input  logic [`HDOWN_ADDR_WIDTH-1:0] haddr,
   input  ahb_pkg::htrans_t             htrans,
   input  ahb_pkg::hsize_t              hsize,
   input  logic                         hwrite,
   input  logic                         hready,
   input  logic [15:0]                  hwdata,
   output logic [15:0]                  hrdata,
   output logic                         hreadyout,
   output logic                         hresp
);
   import ahb_pkg::*;

   localparam int DEPTH = `HDOWN_MEM_DEPTH;
   localparam int WS    = `HDOWN_WAIT_STATES;
   localparam int IW    = $clog2(DEPTH);
   localparam int CW    = (WS > 0) ? $clog2(WS + 1) : 1;

   logic [15:0]   mem [0:DEPTH-1];

   // Data-phase control
   logic          dp_active;
   logic          readyout_q;
   logic          resp_q;
   logic [CW-1:0] wait_cnt;

   // Data-phase payload
   logic          dp_write;
   logic [IW-1:0] dp_idx;
   logic [1:0]    dp_be;

   logic          take;
   logic          out_of_range;

   // ------------------------------------------------------------------------
   // Address phase
   // ------------------------------------------------------------------------

   assign take         = hsel & htrans[1] & hready;
   // Halfword index at or past the depth
   assign out_of_range = (haddr[`HDOWN_ADDR_WIDTH-1:1] >= DEPTH);

   always_ff @(posedge HCLK or negedge HRESETn) begin
      if (!HRESETn) begin
         dp_active  <= 1'b0;
         readyout_q <= 1'b1;
         resp_q     <= HRESP_OKAY;
         wait_cnt   <= '0;
      end else if (hready) begin
         dp_active  <= take;
         resp_q     <= (take && out_of_range) ? HRESP_ERROR : HRESP_OKAY;
         // Errors skip the wait states
         readyout_q <= ~(take & (out_of_range | (WS > 0)));
         wait_cnt   <= CW'(WS);
      end else if (resp_q) begin
         // Second ERROR cycle
         readyout_q <= 1'b1;
      end else begin
         wait_cnt   <= wait_cnt - 1'b1;
         readyout_q <= (wait_cnt == CW'(1));
      end
   end

   always_ff @(posedge HCLK) begin
      if (take) begin
         dp_write <= hwrite;
         dp_idx   <= haddr[IW:1];
         // Single byte picks its lane from bit 0
         if (hsize == HSIZE_BYTE) begin
            dp_be <= haddr[0] ? 2'b10 : 2'b01;
         end else begin
            dp_be <= 2'b11;
         end
      end
   end

   // ------------------------------------------------------------------------
   // Storage
   // ------------------------------------------------------------------------

   // Write on the completing edge, never for an erroring beat
   always_ff @(posedge HCLK) begin
      if (dp_active && hready && dp_write && !resp_q) begin
         if (dp_be[0]) begin
            mem[dp_idx][7:0] <= hwdata[7:0];
         end
         if (dp_be[1]) begin
            mem[dp_idx][15:8] <= hwdata[15:8];
         end
      end
   end

   // Full halfword always read
   assign hrdata    = mem[dp_idx];
   assign hreadyout = readyout_q;
   assign hresp     = resp_q;

endmodule

//--- design/hdown_top.sv
// hdown subsystem top level
// Command master, 32-to-16 bridge and 16-bit SRAM wired together

`timescale 1ns/1ps
`include "hdown_settings.svh"

module hdown_top (
   input  logic                         HCLK,
   input  logic                         HRESETn,
   input  logic                         cmd_valid,
   output logic                         cmd_ready,
   input  logic                         cmd_write,
   input  cmd_pkg::cmd_size_t           cmd_size,
   input  logic [`HDOWN_ADDR_WIDTH-1:0] cmd_addr,
   input  cmd_pkg::cmd_data_t           cmd_wdata,
   output logic                         rsp_valid,
   output cmd_pkg::cmd_data_t           rsp_rdata,
   output logic                         rsp_err
);
   import ahb_pkg::*;

   // 32-bit bus, master to bridge
   logic [`HDOWN_ADDR_WIDTH-1:0] s_haddr;
   htrans_t                      s_htrans;
   hsize_t                       s_hsize;
   logic                         s_hwrite;
   logic [31:0]                  s_hwdata;
   logic [31:0]                  s_hrdata;
   logic                         s_hready;
   logic                         s_hresp;

   // 16-bit bus, bridge to memory
   logic [`HDOWN_ADDR_WIDTH-1:0] m_haddr;
   htrans_t                      m_htrans;
   hsize_t                       m_hsize;
   logic                         m_hwrite;
   logic [15:0]                  m_hwdata;
   logic [15:0]                  m_hrdata;
   logic                         m_hready;
   logic                         m_hresp;

   ahb_cmd_master u_master (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_write (cmd_write),
      .cmd_size  (cmd_size),
      .cmd_addr  (cmd_addr),
      .cmd_wdata (cmd_wdata),
      .rsp_valid (rsp_valid),
      .rsp_rdata (rsp_rdata),
      .rsp_err   (rsp_err),
      .haddr     (s_haddr),
      .htrans    (s_htrans),
      .hsize     (s_hsize),
      .hwrite    (s_hwrite),
      .hwdata    (s_hwdata),
      .hrdata    (s_hrdata),
      .hready    (s_hready),
      .hresp     (s_hresp)
   );

   // Only slave on each bus, so selects are tied high
   ahb_downsizer u_bridge (
      .HCLK        (HCLK),
      .HRESETn     (HRESETn),
      .s_haddr     (s_haddr),
      .s_hsel      (1'b1),
      .s_htrans    (s_htrans),
      .s_hsize     (s_hsize),
      .s_hwrite    (s_hwrite),
      .s_hready    (s_hready),
      .s_hwdata    (s_hwdata),
      .s_hrdata    (s_hrdata),
      .s_hreadyout (s_hready),
      .s_hresp     (s_hresp),
      .m_haddr     (m_haddr),
      .m_htrans    (m_htrans),
      .m_hsize     (m_hsize),
      .m_hwrite    (m_hwrite),
      .m_hwdata    (m_hwdata),
      .m_hrdata    (m_hrdata),
      .m_hready    (m_hready),
      .m_hresp     (m_hresp)
   );

   // Memory ready loops back as its own HREADY
   ahb_sram16 u_sram (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .hsel      (1'b1),
      .haddr     (m_haddr),
      .htrans    (m_htrans),
      .hsize     (m_hsize),
      .hwrite    (m_hwrite),
      .hready    (m_hready),
      .hwdata    (m_hwdata),
      .hrdata    (m_hrdata),
      .hreadyout (m_hready),
      .hresp     (m_hresp)
   );

endmodule

//--- testbench/hdown_tb.sv
// Directed testbench for the hdown subsystem
// Clock and reset, command driver, reference memory, in-order response checker

`timescale 1ns/1ps
`include "hdown_settings.svh"

module hdown_tb;
   import ahb_pkg::*;
   import cmd_pkg::*;

   localparam int AW        = `HDOWN_ADDR_WIDTH;
   localparam int MEM_BYTES = 2 * `HDOWN_MEM_DEPTH;
   localparam int TIMEOUT   = 200;

   logic          HCLK;
   logic          HRESETn;
   logic          cmd_valid;
   logic          cmd_ready;
   logic          cmd_write;
   cmd_size_t     cmd_size;
   logic [AW-1:0] cmd_addr;
   logic [31:0]   cmd_wdata;
   logic          rsp_valid;
   logic [31:0]   rsp_rdata;
   logic          rsp_err;

   // Halfword image of the SRAM updated as write commands are issued
   logic [15:0]   ref_mem [0:`HDOWN_MEM_DEPTH-1];

   // Expected responses in command order
   logic [31:0]   exp_data_q [$];
   logic          exp_err_q [$];
   logic          exp_chk_q [$];

   integer        seed;

   hdown_top hdown_top_i (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_write (cmd_write),
      .cmd_size  (cmd_size),
      .cmd_addr  (cmd_addr),
      .cmd_wdata (cmd_wdata),
      .rsp_valid (rsp_valid),
      .rsp_rdata (rsp_rdata),
      .rsp_err   (rsp_err)
   );

   // 8 ns clock
   initial begin
      HCLK = 1'b0;
      forever #4 HCLK = ~HCLK;
   end

   // ------------------------------------------------------------------------
   // Reporting
   // ------------------------------------------------------------------------

   task automatic abort_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
      if (actual !== expected) begin
         abort_run($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                             $time, name, actual, expected));
      end
   endtask

   // ------------------------------------------------------------------------
   // Command driver
   // ------------------------------------------------------------------------

   // Called 1 ns after a rising edge and returns 1 ns after the accepting edge
   task automatic send_cmd(input logic write, input cmd_size_t size,
                           input logic [AW-1:0] addr, input logic [31:0] wdata);
      int unsigned idx;
      int          waited;
      logic        in_range;
      idx      = addr >> 1;
      in_range = (addr < MEM_BYTES);
      waited   = 0;
      // Expected read data from the state left by all earlier commands
      exp_err_q.push_back(!in_range);
      exp_chk_q.push_back(!write && in_range);
      if (size == CMD_WORD) begin
         exp_data_q.push_back({ref_mem[idx+1], ref_mem[idx]});
      end else begin
         // Sub-word reads come back as the halfword on both halves
         exp_data_q.push_back({ref_mem[idx], ref_mem[idx]});
      end
      // Out-of-range writes leave memory untouched
      if (write && in_range) begin
         case (size)
            CMD_BYTE: ref_mem[idx][8*addr[0] +: 8] = wdata[8*addr[1:0] +: 8];
            CMD_HALF: ref_mem[idx] = wdata[16*addr[1] +: 16];
            default: begin
               ref_mem[idx]   = wdata[15:0];
               ref_mem[idx+1] = wdata[31:16];
            end
         endcase
      end
      cmd_valid = 1'b1;
      cmd_write = write;
      cmd_size  = size;
      cmd_addr  = addr;
      cmd_wdata = wdata;
      // cmd_ready only moves on rising edges and is sampled mid-cycle
      @(negedge HCLK);
      while (!cmd_ready) begin
         waited++;
         if (waited >= TIMEOUT) begin
            abort_run("timeout: cmd_ready stayed low for 200 cycles");
         end else begin
            @(negedge HCLK);
         end
      end
      @(posedge HCLK);
      #1;
   endtask

   task automatic release_cmd();
      cmd_valid = 1'b0;
      cmd_write = 1'b0;
   endtask

   task automatic wait_responses();
      int waited;
      waited = 0;
      while (exp_err_q.size() != 0) begin
         if (waited >= TIMEOUT) begin
            abort_run("timeout: responses still outstanding after 200 cycles");
         end else begin
            @(posedge HCLK);
            waited++;
         end
      end
      @(posedge HCLK);
      #1;
   endtask

   // ------------------------------------------------------------------------
   // Response checker
   // ------------------------------------------------------------------------

   initial begin : rsp_monitor
      logic [31:0] exp_data;
      logic        exp_err;
      logic        exp_chk;
      forever begin
         @(negedge HCLK);
         if (HRESETn && rsp_valid) begin
            if (exp_err_q.size() == 0) begin
               abort_run("rsp_valid high with no command outstanding");
            end else begin
               exp_data = exp_data_q.pop_front();
               exp_err  = exp_err_q.pop_front();
               exp_chk  = exp_chk_q.pop_front();
               check("rsp_err", rsp_err, exp_err);
               // Read data only for good reads
               if (exp_chk) begin
                  check("rsp_rdata", rsp_rdata, exp_data);
               end
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------------------

   task automatic verify_reset_state();
      repeat (4) begin
         @(negedge HCLK);
         check("cmd_ready", cmd_ready, 32'd1);
         check("rsp_valid", rsp_valid, 32'd0);
      end
      @(posedge HCLK);
      #1;
   endtask

   task automatic word_write_readback();
      logic [AW-1:0] addrs [4];
      addrs = '{16'h0000, 16'h0004, 16'h0010, 16'h07fc};
      foreach (addrs[i]) begin
         send_cmd(1'b1, CMD_WORD, addrs[i], $random(seed));
      end
      foreach (addrs[i]) begin
         send_cmd(1'b0, CMD_WORD, addrs[i], 32'h0);
      end
      release_cmd();
      wait_responses();
   endtask

   task automatic merge_sub_word_writes();
      send_cmd(1'b1, CMD_HALF, 16'h0100, 32'h0000_a1b2);
      send_cmd(1'b1, CMD_HALF, 16'h0102, 32'hc3d4_0000);
      send_cmd(1'b0, CMD_WORD, 16'h0100, 32'h0);
      // Bytes in lanes 1 and 2 land inside both halfwords
      send_cmd(1'b1, CMD_BYTE, 16'h0101, 32'h0000_5e00);
      send_cmd(1'b1, CMD_BYTE, 16'h0102, 32'h0077_0000);
      send_cmd(1'b0, CMD_WORD, 16'h0100, 32'h0);
      send_cmd(1'b1, CMD_BYTE, 16'h0100, 32'h0000_0019);
      send_cmd(1'b1, CMD_BYTE, 16'h0103, 32'h8800_0000);
      send_cmd(1'b0, CMD_WORD, 16'h0100, 32'h0);
      send_cmd(1'b0, CMD_HALF, 16'h0100, 32'h0);
      send_cmd(1'b0, CMD_HALF, 16'h0102, 32'h0);
      send_cmd(1'b0, CMD_BYTE, 16'h0101, 32'h0);
      send_cmd(1'b0, CMD_BYTE, 16'h0103, 32'h0);
      release_cmd();
      wait_responses();
      // Hand-merged value of all six writes
      check("merged word 0x100", {ref_mem[129], ref_mem[128]}, 32'h8877_5e19);
   endtask

   task automatic pipeline_random_mix();
      logic [31:0]   pick;
      logic [AW-1:0] addr;
      cmd_size_t     size;
      // Fill the window first so that every read is defined
      for (int i = 0; i < 8; i++) begin
         send_cmd(1'b1, CMD_WORD, AW'(16'h0200 + 4 * i), $random(seed));
      end
      // cmd_valid stays high across all 16 commands
      for (int n = 0; n < 16; n++) begin
         pick = $random(seed);
         addr = 16'h0200 + {pick[4:2], 2'b00};
         case (pick[9:8])
            2'd0: begin
               size = CMD_BYTE;
               addr = addr + pick[1:0];
            end
            2'd1: begin
               size = CMD_HALF;
               addr = addr + {pick[1], 1'b0};
            end
            default: size = CMD_WORD;
         endcase
         send_cmd(pick[12], size, addr, $random(seed));
      end
      release_cmd();
      wait_responses();
   endtask

   task automatic out_of_range_errors();
      send_cmd(1'b1, CMD_WORD, 16'h0040, 32'h1357_9bdf);
      send_cmd(1'b0, CMD_WORD, 16'h0040, 32'h0);
      // 0x840 has the same low index bits as 0x040
      send_cmd(1'b0, CMD_WORD, 16'h0840, 32'h0);
      send_cmd(1'b1, CMD_WORD, 16'h0840, 32'hdead_beef);
      send_cmd(1'b1, CMD_HALF, 16'hfffe, 32'h5555_0000);
      send_cmd(1'b0, CMD_WORD, 16'h0040, 32'h0);
      release_cmd();
      wait_responses();
   endtask

   task automatic recover_after_error();
      send_cmd(1'b0, CMD_HALF, 16'h0900, 32'h0);
      send_cmd(1'b0, CMD_WORD, 16'h0040, 32'h0);
      send_cmd(1'b1, CMD_BYTE, 16'h0a01, 32'h0000_ab00);
      send_cmd(1'b1, CMD_WORD, 16'h0044, 32'h2468_ace0);
      send_cmd(1'b0, CMD_WORD, 16'h0044, 32'h0);
      send_cmd(1'b0, CMD_BYTE, 16'h0a02, 32'h0);
      send_cmd(1'b0, CMD_HALF, 16'h0046, 32'h0);
      release_cmd();
      wait_responses();
   endtask

   // ------------------------------------------------------------------------
   // Sequence
   // ------------------------------------------------------------------------

   initial begin
      seed      = 32'he76ef449;
      HRESETn   = 1'b0;
      cmd_valid = 1'b0;
      cmd_write = 1'b0;
      cmd_size  = CMD_BYTE;
      cmd_addr  = '0;
      cmd_wdata = '0;
      repeat (8) @(posedge HCLK);
      #1;
      HRESETn = 1'b1;
      verify_reset_state();
      word_write_readback();
      merge_sub_word_writes();
      pipeline_random_mix();
      out_of_range_errors();
      recover_after_error();
      $display(">>> PASS");
      $finish;
   end

endmodule

//--- hdown.f
+incdir+include
design/ahb_pkg.sv
design/cmd_pkg.sv
design/ahb_cmd_master.sv
design/ahb_downsizer.sv
design/ahb_sram16.sv
design/hdown_top.sv
testbench/hdown_tb.sv
